/* source/soc_params.svh */
//------------------------------
// Bus widths and block map
// CSR offsets of the GPIO and video blocks
// Display timing widths and reset values
//------------------------------
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define BUS_ADRS_BIT		32
`define USI_DATA_WIDTH		32
`define BLOCK_ADRS_MAP		4
`define CSR_ADRS_WIDTH		16

// Block numbers in address bits 31:28
`define GPIO_ADRS_MAP		4'd1
`define VTB_ADRS_MAP		4'd4

// GPIO CSR
`define CSR_LED				16'd0

// Video CSR word offsets
`define CSR_HDISPLAY		16'd0
`define CSR_HFRONT			16'd1
`define CSR_HBACK			16'd2
`define CSR_HPULSE			16'd3
`define CSR_VDISPLAY		16'd4
`define CSR_VFRONT			16'd5
`define CSR_VBACK			16'd6
`define CSR_VPULSE			16'd7
`define CSR_VTB_ENABLE		16'd8

// Timing register widths
`define HDISPLAY_WIDTH		11
`define HPORCH_WIDTH		7
`define VDISPLAY_WIDTH		11
`define VPORCH_WIDTH		5

// 480x272 panel timing after reset
`define HDISPLAY_INIT		11'd480
`define HFRONT_INIT			7'd8
`define HBACK_INIT			7'd43
`define HPULSE_INIT			7'd30
`define VDISPLAY_INIT		11'd272
`define VFRONT_INIT			5'd12
`define VBACK_INIT			5'd4
`define VPULSE_INIT			5'd10

// Read data for a block with no slave
`define UNMAPPED_READ		32'h0000_0000

`endif

/* source/busPkg.sv */
//------------------------------
// Register bus types
// Address union, host request struct
// and per-slave command struct
//------------------------------
`include "soc_params.svh"

package busPkg;

	// One bus data word
	typedef logic [`USI_DATA_WIDTH-1:0] usiDataT;

	//------------------------------
	// Address views
	//------------------------------
	// Field view, block number on top and CSR offset at the bottom
	typedef struct packed {
		logic [`BLOCK_ADRS_MAP-1:0]										blockSel;
		logic [`BUS_ADRS_BIT-`BLOCK_ADRS_MAP-`CSR_ADRS_WIDTH-1:0]		gap;
		logic [`CSR_ADRS_WIDTH-1:0]										csrAdrs;
	} usiAdrsFieldS;

	// Host writes raw, the bus reads the fields
	typedef union packed {
		logic [`BUS_ADRS_BIT-1:0]	raw;
		usiAdrsFieldS				field;
	} usiAdrsU;

	//------------------------------
	// Commands
	//------------------------------
	// Host command, 65 bits
	typedef struct packed {
		logic		wr;
		usiAdrsU	adrs;
		usiDataT	wdata;
	} usiReqS;

	// Slave command, wCke already qualified by block select
	typedef struct packed {
		logic							wCke;
		logic [`CSR_ADRS_WIDTH-1:0]		csrAdrs;
		usiDataT						wdata;
	} usiSlaveS;

endpackage

/* source/gpioBlock.sv */
//------------------------------
// GPIO block
// LED control register and read-back
//------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module gpioBlock import busPkg::*;
(
	input  logic							iSysClk,
	input  logic							rstN,
	input  usiSlaveS						cmd,
	output logic [`USI_DATA_WIDTH-1:0]		rd,
	output logic [1:0]						led,
	output logic							ledB,
	output logic							ledG,
	output logic							ledR
);

localparam int ledWidth = 5;

// Bits 1:0 board LEDs, 2 blue, 3 green, 4 red
logic [ledWidth-1:0]	ledReg;

always_ff @(posedge iSysClk)
begin
	if (!rstN)
	begin
		ledReg <= '0;
	end
	else if (cmd.wCke && cmd.csrAdrs == `CSR_LED)
	begin
		ledReg <= cmd.wdata[ledWidth-1:0];
	end
end

// Registered read, zero for any other offset
always_ff @(posedge iSysClk)
begin
	if (cmd.csrAdrs == `CSR_LED)
	begin
		rd <= usiDataT'(ledReg);
	end
	else
	begin
		rd <= '0;
	end
end

assign led  = ledReg[1:0];
assign ledB = ledReg[2];
assign ledG = ledReg[3];
assign ledR = ledReg[4];

endmodule

/* source/videoTxBlock.sv */
//------------------------------
// Video transmit block
// Display timing CSRs, sync counters
// and sync / DE generation
//------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module videoTxBlock import busPkg::*;
(
	input  logic							iSysClk,
	input  logic							rstN,
	input  usiSlaveS						cmd,
	output logic [`USI_DATA_WIDTH-1:0]		rd,
	output logic							tftHSync,
	output logic							tftVSync,
	output logic							tftDe
);

// One extra bit holds display plus three porches
localparam int hCntWidth = `HDISPLAY_WIDTH + 1;
localparam int vCntWidth = `VDISPLAY_WIDTH + 1;

// Timing registers
logic [`HDISPLAY_WIDTH-1:0]		hdisplay;
logic [`HPORCH_WIDTH-1:0]		hfront;
logic [`HPORCH_WIDTH-1:0]		hback;
logic [`HPORCH_WIDTH-1:0]		hpulse;
logic [`VDISPLAY_WIDTH-1:0]		vdisplay;
logic [`VPORCH_WIDTH-1:0]		vfront;
logic [`VPORCH_WIDTH-1:0]		vback;
logic [`VPORCH_WIDTH-1:0]		vpulse;
logic							enable;

// Counters and region boundaries
logic [hCntWidth-1:0]			hCnt;
logic [hCntWidth-1:0]			hSyncStart;
logic [hCntWidth-1:0]			hSyncEnd;
logic [hCntWidth-1:0]			hTotal;
logic [vCntWidth-1:0]			vCnt;
logic [vCntWidth-1:0]			vSyncStart;
logic [vCntWidth-1:0]			vSyncEnd;
logic [vCntWidth-1:0]			vTotal;

//------------------------------
// CSR write
//------------------------------
always_ff @(posedge iSysClk)
begin
	if (!rstN)
	begin
		hdisplay <= `HDISPLAY_INIT;
		hfront   <= `HFRONT_INIT;
		hback    <= `HBACK_INIT;
		hpulse   <= `HPULSE_INIT;
		vdisplay <= `VDISPLAY_INIT;
		vfront   <= `VFRONT_INIT;
		vback    <= `VBACK_INIT;
		vpulse   <= `VPULSE_INIT;
		enable   <= 1'b0;
	end
	else if (cmd.wCke)
	begin
		// Upper data bits are dropped
		case (cmd.csrAdrs)
			`CSR_HDISPLAY:		hdisplay <= cmd.wdata[`HDISPLAY_WIDTH-1:0];
			`CSR_HFRONT:		hfront   <= cmd.wdata[`HPORCH_WIDTH-1:0];
			`CSR_HBACK:			hback    <= cmd.wdata[`HPORCH_WIDTH-1:0];
			`CSR_HPULSE:		hpulse   <= cmd.wdata[`HPORCH_WIDTH-1:0];
			`CSR_VDISPLAY:		vdisplay <= cmd.wdata[`VDISPLAY_WIDTH-1:0];
			`CSR_VFRONT:		vfront   <= cmd.wdata[`VPORCH_WIDTH-1:0];
			`CSR_VBACK:			vback    <= cmd.wdata[`VPORCH_WIDTH-1:0];
			`CSR_VPULSE:		vpulse   <= cmd.wdata[`VPORCH_WIDTH-1:0];
			`CSR_VTB_ENABLE:	enable   <= cmd.wdata[0];
			default:			enable   <= enable;
		endcase
	end
end

//------------------------------
// CSR read
//------------------------------
always_ff @(posedge iSysClk)
begin
	case (cmd.csrAdrs)
		`CSR_HDISPLAY:		rd <= usiDataT'(hdisplay);
		`CSR_HFRONT:		rd <= usiDataT'(hfront);
		`CSR_HBACK:			rd <= usiDataT'(hback);
		`CSR_HPULSE:		rd <= usiDataT'(hpulse);
		`CSR_VDISPLAY:		rd <= usiDataT'(vdisplay);
		`CSR_VFRONT:		rd <= usiDataT'(vfront);
		`CSR_VBACK:			rd <= usiDataT'(vback);
		`CSR_VPULSE:		rd <= usiDataT'(vpulse);
		`CSR_VTB_ENABLE:	rd <= usiDataT'(enable);
		default:			rd <= '0;
	endcase
end

// Display, front porch, pulse, back porch
assign hSyncStart = hCntWidth'(hdisplay) + hCntWidth'(hfront);
assign hSyncEnd   = hSyncStart + hCntWidth'(hpulse);
assign hTotal     = hSyncEnd + hCntWidth'(hback);
assign vSyncStart = vCntWidth'(vdisplay) + vCntWidth'(vfront);
assign vSyncEnd   = vSyncStart + vCntWidth'(vpulse);
assign vTotal     = vSyncEnd + vCntWidth'(vback);

//------------------------------
// Sync counters
//------------------------------
always_ff @(posedge iSysClk)
begin
	if (!rstN || !enable)
	begin
		hCnt <= '0;
		vCnt <= '0;
	end
	else if (hCnt >= hTotal - hCntWidth'(1))
	begin
		// End of line
		hCnt <= '0;
		if (vCnt >= vTotal - vCntWidth'(1))
		begin
			vCnt <= '0;
		end
		else
		begin
			vCnt <= vCnt + vCntWidth'(1);
		end
	end
	else
	begin
		hCnt <= hCnt + hCntWidth'(1);
	end
end

// Outputs registered, syncs active low
always_ff @(posedge iSysClk)
begin
	if (!rstN || !enable)
	begin
		tftDe    <= 1'b0;
		tftHSync <= 1'b1;
		tftVSync <= 1'b1;
	end
	else
	begin
		tftDe    <= (hCnt < hCntWidth'(hdisplay)) && (vCnt < vCntWidth'(vdisplay));
		tftHSync <= !((hCnt >= hSyncStart) && (hCnt < hSyncEnd));
		tftVSync <= !((vCnt >= vSyncStart) && (vCnt < vSyncEnd));
	end
end

endmodule

/* source/usiBus.sv */
//------------------------------
// Register bus
// Four-phase host handshake, block decode,
// write fan-out and read gather
//------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module usiBus import busPkg::*;
(
	input  logic							iSysClk,
	input  logic							rstN,
	// Host side
	input  logic							req,
	input  usiReqS							usiReq,
	output logic							ack,
	output logic [`USI_DATA_WIDTH-1:0]		rdata,
	// Slave side
	output usiSlaveS						gpioCmd,
	output usiSlaveS						vtbCmd,
	input  logic [`USI_DATA_WIDTH-1:0]		gpioRd,
	input  logic [`USI_DATA_WIDTH-1:0]		vtbRd
);

typedef enum logic [2:0] {
	stIdle,
	stAccess,
	stCapture,
	stAckWait,
	stRelease
} busStateT;

busStateT							state;
usiReqS								reqQ;
logic								gpioSel;
logic								vtbSel;
logic [`USI_DATA_WIDTH-1:0]			selRd;

// Block decode through the field view
assign gpioSel = (reqQ.adrs.field.blockSel == `GPIO_ADRS_MAP);
assign vtbSel  = (reqQ.adrs.field.blockSel == `VTB_ADRS_MAP);

// Latch the command when a new request is accepted
always_ff @(posedge iSysClk)
begin
	if (state == stIdle && req && !ack)
	begin
		reqQ <= usiReq;
	end
end

//------------------------------
// Handshake FSM
//------------------------------
always_ff @(posedge iSysClk)
begin
	if (!rstN)
	begin
		state <= stIdle;
		ack   <= 1'b0;
	end
	else
	begin
		case (state)
			stIdle:
			begin
				if (req && !ack)
				begin
					state <= stAccess;
				end
			end
			stAccess:
			begin
				state <= stCapture;
			end
			stCapture:
			begin
				ack   <= 1'b1;
				state <= stAckWait;
			end
			stAckWait:
			begin
				// Host has dropped req, release the bus
				if (!req)
				begin
					ack   <= 1'b0;
					state <= stRelease;
				end
			end
			stRelease:
			begin
				state <= stIdle;
			end
			default:
			begin
				state <= stIdle;
			end
		endcase
	end
end

//------------------------------
// Write fan-out
//------------------------------
// Offset and data go to both slaves, only the selected one gets wCke
always_comb
begin
	gpioCmd.wCke    = (state == stAccess) && reqQ.wr && gpioSel;
	gpioCmd.csrAdrs = reqQ.adrs.field.csrAdrs;
	gpioCmd.wdata   = reqQ.wdata;
	vtbCmd.wCke     = (state == stAccess) && reqQ.wr && vtbSel;
	vtbCmd.csrAdrs  = reqQ.adrs.field.csrAdrs;
	vtbCmd.wdata    = reqQ.wdata;
end

//------------------------------
// Read gather
//------------------------------
always_comb
begin
	if (gpioSel)
	begin
		selRd = gpioRd;
	end
	else if (vtbSel)
	begin
		selRd = vtbRd;
	end
	else
	begin
		selRd = `UNMAPPED_READ;
	end
end

// Slave rd is registered during access, so take it one cycle later
always_ff @(posedge iSysClk)
begin
	if (state == stCapture)
	begin
		rdata <= selRd;
	end
end

endmodule

/* source/processor.sv */
//------------------------------
// Processor top
// Host port, register bus, GPIO and video
//------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module processor import busPkg::*;
(
	input  logic							iSysClk,
	input  logic							rstN,
	// Host port
	input  logic							req,
	input  usiReqS							usiReq,
	output logic							ack,
	output logic [`USI_DATA_WIDTH-1:0]		rdata,
	// LED
	output logic [1:0]						led,
	output logic							ledB,
	output logic							ledG,
	output logic							ledR,
	// Display sync
	output logic							tftHSync,
	output logic							tftVSync,
	output logic							tftDe
);

// Bus to slave commands
usiSlaveS							gpioCmd;
usiSlaveS							vtbCmd;
// Slave read words
logic [`USI_DATA_WIDTH-1:0]			gpioRd;
logic [`USI_DATA_WIDTH-1:0]			vtbRd;

//------------------------------
// Register bus
//------------------------------
usiBus usiBus (
	.iSysClk	(iSysClk),
	.rstN		(rstN),
	.req		(req),
	.usiReq		(usiReq),
	.ack		(ack),
	.rdata		(rdata),
	.gpioCmd	(gpioCmd),
	.vtbCmd		(vtbCmd),
	.gpioRd		(gpioRd),
	.vtbRd		(vtbRd)
);

//------------------------------
// GPIO block
//------------------------------
gpioBlock gpioBlock (
	.iSysClk	(iSysClk),
	.rstN		(rstN),
	.cmd		(gpioCmd),
	.rd			(gpioRd),
	.led		(led),
	.ledB		(ledB),
	.ledG		(ledG),
	.ledR		(ledR)
);

//------------------------------
// Video transmit block
//------------------------------
videoTxBlock videoTxBlock (
	.iSysClk	(iSysClk),
	.rstN		(rstN),
	.cmd		(vtbCmd),
	.rd			(vtbRd),
	.tftHSync	(tftHSync),
	.tftVSync	(tftVSync),
	.tftDe		(tftDe)
);

endmodule

/* tests/clockGen.sv */
//------------------------------
// Testbench clock and reset
// 4 ns clock, reset low 16 cycles
//------------------------------
`timescale 1ns/1ps

module clockGen
(
	output logic	iSysClk,
	output logic	rstN
);

localparam int resetCycles = 16;

initial
begin
	iSysClk = 1'b0;
	forever
	begin
		#2 iSysClk = ~iSysClk;
	end
end

initial
begin
	rstN = 1'b0;
	repeat (resetCycles) @(posedge iSysClk);
	rstN <= 1'b1;
end

endmodule

/* tests/processorTb.sv */
//------------------------------
// Processor testbench
// Pattern-driven host accesses, compare tasks
// and display sync measurement
//------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module processorTb import busPkg::*;
();

localparam int maxOps = 64;

typedef struct packed {
	logic		ledR;
	logic		ledG;
	logic		ledB;
	logic [1:0]	led;
} ledPortsS;

typedef struct packed {
	logic	hSync;
	logic	vSync;
	logic	de;
} syncPortsS;

logic						iSysClk;
logic						rstN;
logic						req;
usiReqS						usiReq;
logic						ack;
usiDataT					rdata;
logic [1:0]					led;
logic						ledB;
logic						ledG;
logic						ledR;
logic						tftHSync;
logic						tftVSync;
logic						tftDe;

// Four words per line: op, address, write data, expected
logic [31:0]				patMem [0:4*maxOps-1];
// Expected timing registers, same order as the CSR offsets
int							timing [8];
int							wordErrors = 0;
int							ledErrors = 0;
int							syncErrors = 0;
int							countErrors = 0;
int							otherErrors = 0;
int							cycles = 0;
int							cycleLimit = 0;

clockGen clockGen (
	.iSysClk	(iSysClk),
	.rstN		(rstN)
);

processor DUT (
	.iSysClk	(iSysClk),
	.rstN		(rstN),
	.req		(req),
	.usiReq		(usiReq),
	.ack		(ack),
	.rdata		(rdata),
	.led		(led),
	.ledB		(ledB),
	.ledG		(ledG),
	.ledR		(ledR),
	.tftHSync	(tftHSync),
	.tftVSync	(tftVSync),
	.tftDe		(tftDe)
);

//------------------------------
// Timing model
//------------------------------
function automatic void resetTiming();
	timing[0] = int'(`HDISPLAY_INIT);
	timing[1] = int'(`HFRONT_INIT);
	timing[2] = int'(`HBACK_INIT);
	timing[3] = int'(`HPULSE_INIT);
	timing[4] = int'(`VDISPLAY_INIT);
	timing[5] = int'(`VFRONT_INIT);
	timing[6] = int'(`VBACK_INIT);
	timing[7] = int'(`VPULSE_INIT);
endfunction

// Writes keep only the low bits of each register
function automatic void applyTiming(input usiDataT adrs, input usiDataT wdata);
	usiAdrsU	a;
	int			off;
	int			width;
	a.raw = adrs;
	off = int'(a.field.csrAdrs);
	if (a.field.blockSel == 4'd4 && off < 8)
	begin
		if (off == 0)
			width = `HDISPLAY_WIDTH;
		else if (off < 4)
			width = `HPORCH_WIDTH;
		else if (off == 4)
			width = `VDISPLAY_WIDTH;
		else
			width = `VPORCH_WIDTH;
		timing[off] = int'(wdata & ((32'd1 << width) - 32'd1));
	end
endfunction

// Line length times lines per frame
function automatic int frameCycles();
	return (timing[0] + timing[1] + timing[2] + timing[3]) *
		(timing[4] + timing[5] + timing[6] + timing[7]);
endfunction

//------------------------------
// Host port
//------------------------------
task automatic runHandshake(input logic wr, input usiDataT adrs, input usiDataT wdata,
	output usiDataT data);
	usiReqS	r;
	r.wr = wr;
	r.adrs.raw = adrs;
	r.wdata = wdata;
	@(posedge iSysClk);
	usiReq <= r;
	req <= 1'b1;
	do @(negedge iSysClk); while (!ack);
	data = rdata;
	@(posedge iSysClk);
	req <= 1'b0;
	do @(negedge iSysClk); while (ack);
endtask

task automatic hostWrite(input usiDataT adrs, input usiDataT wdata);
	usiDataT	unused;
	runHandshake(1'b1, adrs, wdata, unused);
endtask

task automatic hostRead(input usiDataT adrs, output usiDataT data);
	runHandshake(1'b0, adrs, '0, data);
endtask

// Gap ends on a falling edge so the next check sees settled outputs
task automatic idleGap();
	repeat ($urandom % 4) @(negedge iSysClk);
endtask

//------------------------------
// Compare tasks
//------------------------------
task automatic checkWord(input usiDataT adrs, input usiDataT expected, input usiDataT got);
	if (got !== expected)
	begin
		$display("[FAIL] rdata at %h expected %h got %h", adrs, expected, got);
		wordErrors++;
	end
endtask

// Register bits 1:0 led, 2 blue, 3 green, 4 red
task automatic checkLeds(input logic [4:0] pattern);
	ledPortsS	expected;
	ledPortsS	got;
	expected.led = pattern[1:0];
	expected.ledB = pattern[2];
	expected.ledG = pattern[3];
	expected.ledR = pattern[4];
	got.led = led;
	got.ledB = ledB;
	got.ledG = ledG;
	got.ledR = ledR;
	if (got !== expected)
	begin
		$display("[FAIL] {ledR,ledG,ledB,led} expected %h got %h", expected, got);
		ledErrors++;
	end
endtask

task automatic checkSync(input syncPortsS expected);
	syncPortsS	got;
	got.hSync = tftHSync;
	got.vSync = tftVSync;
	got.de = tftDe;
	if (got !== expected)
	begin
		$display("[FAIL] {tftHSync,tftVSync,tftDe} expected %h got %h", expected, got);
		syncErrors++;
	end
endtask

task automatic checkCount(input string name, input int expected, input int got);
	if (got != expected)
	begin
		$display("[FAIL] %s expected %h got %h", name, expected, got);
		countErrors++;
	end
endtask

//------------------------------
// Sync measurement
//------------------------------
// One frame between vSync falls, first full DE and hSync pulse inside it
task automatic measureTiming();
	int		vFalls;
	int		period;
	int		cnt;
	int		deRun;
	int		deWidth;
	int		hLow;
	int		hWidth;
	logic	prevV;
	logic	prevH;
	logic	prevDe;
	vFalls = 0;
	period = 0;
	cnt = 0;
	deRun = 0;
	deWidth = -1;
	hLow = 0;
	hWidth = -1;
	prevV = tftVSync;
	prevH = tftHSync;
	prevDe = tftDe;
	while (vFalls < 2)
	begin
		@(negedge iSysClk);
		if (vFalls == 1)
			cnt++;
		if (prevV && !tftVSync)
		begin
			if (vFalls == 1)
				period = cnt;
			cnt = 0;
			vFalls++;
		end
		if (vFalls > 0)
		begin
			if (tftDe && !prevDe)
				deRun = 0;
			if (tftDe)
				deRun++;
			if (!tftDe && prevDe && deWidth < 0)
				deWidth = deRun;
			if (!tftHSync && prevH)
				hLow = 0;
			if (!tftHSync)
				hLow++;
			if (tftHSync && !prevH && hWidth < 0)
				hWidth = hLow;
		end
		prevV = tftVSync;
		prevH = tftHSync;
		prevDe = tftDe;
	end
	checkCount("tftVSync period", frameCycles(), period);
	checkCount("tftDe high width", timing[0], deWidth);
	checkCount("tftHSync low width", timing[3], hWidth);
endtask

// Watchdog
always @(posedge iSysClk)
begin
	cycles <= cycles + 1;
	if (cycleLimit > 0 && cycles >= cycleLimit)
	begin
		$display("Run timed out after %0d cycles", cycles);
		$display("Testbench failed");
		$finish;
	end
end

//------------------------------
// Main sequence
//------------------------------
initial
begin
	int			nOps;
	int			maxFrame;
	int			total;
	logic [3:0]	op;
	usiDataT	adrs;
	usiDataT	wdata;
	usiDataT	expected;
	usiDataT	got;
	req = 1'b0;
	usiReq = '0;
	void'($urandom(93226));
	$readmemh("tests/busPatterns.hex", patMem);
	nOps = 0;
	while (nOps < maxOps && patMem[4*nOps][3:0] != 4'hF)
		nOps++;
	// Longest programmed frame sets the time budget
	resetTiming();
	maxFrame = 0;
	for (int i = 0; i < nOps; i++)
	begin
		if (patMem[4*i][3:0] == 4'h0)
			applyTiming(patMem[4*i+1], patMem[4*i+2]);
		if (patMem[4*i][3:0] == 4'h3 && frameCycles() > maxFrame)
			maxFrame = frameCycles();
	end
	cycleLimit = nOps * 20 + 3 * maxFrame * 2 + 200;
	resetTiming();
	wait (rstN === 1'b1);
	@(negedge iSysClk);
	for (int i = 0; i < nOps; i++)
	begin
		op = patMem[4*i][3:0];
		adrs = patMem[4*i+1];
		wdata = patMem[4*i+2];
		expected = patMem[4*i+3];
		case (op)
			4'h0:
			begin
				hostWrite(adrs, wdata);
				applyTiming(adrs, wdata);
			end
			4'h1:
			begin
				hostRead(adrs, got);
				checkWord(adrs, expected, got);
			end
			4'h2:
				checkLeds(expected[4:0]);
			4'h3:
				measureTiming();
			4'h4:
				checkSync(3'b110);
			default:
			begin
				$display("Unknown operation code %h on pattern line %0d", op, i);
				otherErrors++;
			end
		endcase
		idleGap();
	end
	total = wordErrors + ledErrors + syncErrors + countErrors + otherErrors;
	$display("Errors: rdata %0d, leds %0d, sync %0d, counts %0d, other %0d",
		wordErrors, ledErrors, syncErrors, countErrors, otherErrors);
	if (total == 0)
		$display("Testbench passed");
	else
		$display("Testbench failed");
	$finish;
end

endmodule

/* tests/busPatterns.hex */
// op address data expected
// op 0 write, 1 read, 2 LED ports, 3 measure sync, 4 sync idle, F end
4 00000000 00000000 00000000 // outputs after reset
2 00000000 00000000 00000000
1 40000000 00000000 000001E0
1 40000001 00000000 00000008
1 40000002 00000000 0000002B
1 40000003 00000000 0000001E
1 40000004 00000000 00000110
1 40000005 00000000 0000000C
1 40000006 00000000 00000004
1 40000007 00000000 0000000A
1 40000008 00000000 00000000
0 10000000 FFFFFFE5 00000000 // GPIO
2 00000000 00000000 00000005
1 10000000 00000000 00000005
0 10000000 0000001A 00000000
2 00000000 00000000 0000001A
1 10000000 00000000 0000001A
1 10000005 00000000 00000000
0 40000000 0000F80C 00000000 // small timing, some truncated
0 40000001 00000083 00000000
0 40000002 00000085 00000000
0 40000003 00000004 00000000
0 40000004 00000006 00000000
0 40000005 00000022 00000000
0 40000006 00000002 00000000
0 40000007 000000E3 00000000
1 40000000 00000000 0000000C
1 40000001 00000000 00000003
1 40000002 00000000 00000005
1 40000003 00000000 00000004
1 40000004 00000000 00000006
1 40000005 00000000 00000002
1 40000006 00000000 00000002
1 40000007 00000000 00000003
1 40000009 00000000 00000000
0 20000000 12345678 00000000 // unmapped blocks
1 20000000 00000000 00000000
0 70000003 0000007F 00000000
1 70000003 00000000 00000000
2 00000000 00000000 0000001A
1 10000000 00000000 0000001A
1 40000000 00000000 0000000C
1 40000003 00000000 00000004
0 40000008 00000001 00000000 // video on
1 40000008 00000000 00000001
3 00000000 00000000 00000000
0 40000008 00000000 00000000 // video off
4 00000000 00000000 00000000
F 00000000 00000000 00000000

/* sim.f */
+incdir+source
source/busPkg.sv
source/gpioBlock.sv
source/videoTxBlock.sv
source/usiBus.sv
source/processor.sv
tests/clockGen.sv
tests/processorTb.sv

/* run.sh */
#!/bin/sh
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module processorTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VprocessorTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
